//--- cr_link_train.f
design/cr_pkg.sv
design/cr_param_store.sv
design/cr_train_seq.sv
design/cr_aux_request.sv
design/cr_handoff_out.sv
design/cr_link_train.sv
test/tb_clk_gen.sv
test/tb_cr_link_train.sv

//--- design/cr_aux_request.sv
// Requests appear one cycle after their state; lane count code 2 writes four lane bytes
module cr_aux_request (
  input  logic                          clk,
  input  logic                          rst_n,
  input  cr_pkg::cr_state_t             state,
  input  logic [cr_pkg::bw_w-1:0]       link_bw,
  input  logic [cr_pkg::lc_w-1:0]       link_lc,
  input  logic [cr_pkg::lvl_word_w-1:0] vtg_lvl,
  input  logic [cr_pkg::lvl_word_w-1:0] pre_lvl,
  input  logic [cr_pkg::lane_lvl_w-1:0] max_vtg_lvl,
  input  logic [cr_pkg::lane_lvl_w-1:0] max_pre_lvl,
  input  logic                          drive_retry,
  output logic                          cr_transaction_vld,
  output logic [cr_pkg::aux_cmd_w-1:0]  cr_cmd,
  output logic [cr_pkg::aux_addr_w-1:0] cr_address,
  output logic [cr_pkg::aux_len_w-1:0]  cr_len,
  output cr_pkg::aux_byte_u             cr_data
);

  logic [1:0]                    lane_sel;
  logic [cr_pkg::lane_lvl_w-1:0] lane_vtg;
  logic [cr_pkg::lane_lvl_w-1:0] lane_pre;
  cr_pkg::lane_drive_s           lane_byte;
  logic [cr_pkg::aux_len_w-1:0]  lane_cnt;
  logic [7:0]                    lc_byte;
  logic                          waiting;

  // Lane served by the current lane state
  always_comb
  begin
    case (state)
      cr_pkg::st_lane1: lane_sel = 2'd1;
      cr_pkg::st_lane2: lane_sel = 2'd2;
      cr_pkg::st_lane3: lane_sel = 2'd3;
      default:          lane_sel = 2'd0;
    endcase
  end

  assign lane_vtg = vtg_lvl[lane_sel*cr_pkg::lane_lvl_w +: cr_pkg::lane_lvl_w];
  assign lane_pre = pre_lvl[lane_sel*cr_pkg::lane_lvl_w +: cr_pkg::lane_lvl_w];

  always_comb
  begin
    lane_byte                 = '0;
    lane_byte.vtg_lvl         = lane_vtg;
    lane_byte.pre_lvl         = lane_pre;
    lane_byte.max_vtg_reached = (lane_vtg == max_vtg_lvl);
    lane_byte.max_pre_reached = (lane_pre == max_pre_lvl);
  end

  // Active lanes; the invalid code counts as one
  always_comb
  begin
    case (link_lc)
      2'd3:    lane_cnt = 8'd4;
      2'd1:    lane_cnt = 8'd2;
      default: lane_cnt = 8'd1;
    endcase
  end

  // Lane count is sent as code + 1 with enhanced framing on
  assign lc_byte = (8'(link_lc) + 8'd1) | (8'd1 << cr_pkg::enh_frame_bit);

  assign waiting = state inside {cr_pkg::st_wait_ack_cfg, cr_pkg::st_wait_ack_drive,
                                 cr_pkg::st_wait_ctr_fire, cr_pkg::st_wait_ack_status,
                                 cr_pkg::st_wait_data_status, cr_pkg::st_wait_ack_adjust,
                                 cr_pkg::st_wait_data_adjust};

  //////////////////////////////////////////////////
  // Registered request, continuation cycles carry no header
  //////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      cr_transaction_vld <= 1'b0;
      cr_cmd             <= '0;
      cr_address         <= '0;
      cr_len             <= '0;
      cr_data            <= '0;
    end
    else
    begin
      cr_transaction_vld <= 1'b0;
      cr_cmd             <= '0;
      cr_address         <= '0;
      cr_len             <= '0;
      cr_data            <= '0;
      case (state)
        cr_pkg::st_cfg_byte1:
        begin
          cr_transaction_vld <= 1'b1;
          cr_cmd             <= cr_pkg::aux_cmd_write;
          cr_address         <= cr_pkg::dpcd_link_bw_set;
          cr_len             <= 8'd2;
          cr_data.raw        <= link_bw;
        end
        cr_pkg::st_cfg_byte2:
        begin
          cr_transaction_vld <= 1'b1;
          cr_data.raw        <= lc_byte;
        end
        cr_pkg::st_cfg_byte3:
          cr_transaction_vld <= 1'b1;
        cr_pkg::st_phy_cfg:
        begin
          cr_transaction_vld <= 1'b1;
          cr_cmd             <= cr_pkg::aux_cmd_write;
          cr_address         <= cr_pkg::dpcd_training_pattern_set;
          cr_len             <= lane_cnt;
          cr_data.raw        <= cr_pkg::tps1_no_scramble;
        end
        cr_pkg::st_lane0, cr_pkg::st_lane1, cr_pkg::st_lane2, cr_pkg::st_lane3:
        begin
          cr_transaction_vld <= 1'b1;
          cr_data.drive      <= lane_byte;
          // A retry skips the pattern byte, so lane 0 opens its own burst
          if (drive_retry && state == cr_pkg::st_lane0)
          begin
            cr_cmd     <= cr_pkg::aux_cmd_write;
            cr_address <= cr_pkg::dpcd_training_lane0_set;
            cr_len     <= lane_cnt - 8'd1;
          end
        end
        cr_pkg::st_read_status, cr_pkg::st_read_adjust:
        begin
          cr_transaction_vld <= 1'b1;
          cr_cmd             <= cr_pkg::aux_cmd_read;
          cr_address         <= (state == cr_pkg::st_read_status) ?
                                cr_pkg::dpcd_lane01_status : cr_pkg::dpcd_adjust_request;
          cr_len             <= 8'd1;
        end
        default: ;
      endcase
    end
  end

  a_no_req_after_wait: assert property (@(posedge clk) disable iff (!rst_n)
    waiting |=> !cr_transaction_vld)
    else $error("AUX request issued after a wait state");

endmodule

//--- design/cr_handoff_out.sv
// All handoff data reads zero except in the one cycle that carries it
module cr_handoff_out (
  input  logic                          clk,
  input  logic                          rst_n,
  input  cr_pkg::cr_state_t             state,
  input  logic [cr_pkg::bw_w-1:0]       link_bw,
  input  logic [cr_pkg::lc_w-1:0]       link_lc,
  input  logic [cr_pkg::lvl_word_w-1:0] vtg_lvl,
  input  logic [cr_pkg::lvl_word_w-1:0] pre_lvl,
  output logic                          eq_start,
  output logic                          cr_completed,
  output logic [cr_pkg::lvl_word_w-1:0] new_vtg,
  output logic [cr_pkg::lvl_word_w-1:0] new_pre,
  output logic [cr_pkg::bw_w-1:0]       new_bw,
  output logic [cr_pkg::lc_w-1:0]       new_lc,
  output logic                          cr_chk_start,
  output logic [cr_pkg::lvl_word_w-1:0] adj_vtg,
  output logic [cr_pkg::lvl_word_w-1:0] adj_pre,
  output logic                          fsm_cr_failed,
  output logic                          cr_ctr_start,
  output logic [1:0]                    cr_phy_instruct,
  output logic                          cr_phy_instruct_vld,
  output logic [cr_pkg::lc_w-1:0]       cr_adj_lc,
  output logic [cr_pkg::bw_w-1:0]       cr_adj_bw
);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      eq_start            <= 1'b0;
      cr_completed        <= 1'b0;
      new_vtg             <= '0;
      new_pre             <= '0;
      new_bw              <= '0;
      new_lc              <= '0;
      cr_chk_start        <= 1'b0;
      adj_vtg             <= '0;
      adj_pre             <= '0;
      fsm_cr_failed       <= 1'b0;
      cr_ctr_start        <= 1'b0;
      cr_phy_instruct     <= '0;
      cr_phy_instruct_vld <= 1'b0;
      cr_adj_lc           <= '0;
      cr_adj_bw           <= '0;
    end
    else
    begin
      // Equalization stage takes over with the settings that passed
      eq_start     <= (state == cr_pkg::st_eq_start);
      cr_completed <= (state == cr_pkg::st_eq_start);
      new_vtg      <= (state == cr_pkg::st_eq_start) ? vtg_lvl : '0;
      new_pre      <= (state == cr_pkg::st_eq_start) ? pre_lvl : '0;
      new_bw       <= (state == cr_pkg::st_eq_start) ? link_bw : '0;
      new_lc       <= (state == cr_pkg::st_eq_start) ? link_lc : '0;
      // Error checker gets the levels the sink asked for
      cr_chk_start <= (state == cr_pkg::st_err_chk_start);
      adj_vtg      <= (state == cr_pkg::st_err_chk_start) ? vtg_lvl : '0;
      adj_pre      <= (state == cr_pkg::st_err_chk_start) ? pre_lvl : '0;

      fsm_cr_failed <= (state == cr_pkg::st_cr_failed);
      // Level, held through the whole timer wait
      cr_ctr_start  <= (state == cr_pkg::st_wait_ctr_fire);

      cr_phy_instruct_vld <= (state == cr_pkg::st_phy_cfg);
      cr_phy_instruct     <= (state == cr_pkg::st_phy_cfg) ? cr_pkg::phy_instr_cr : '0;
      cr_adj_lc           <= (state == cr_pkg::st_phy_cfg) ? link_lc : '0;
      cr_adj_bw           <= (state == cr_pkg::st_phy_cfg) ? link_bw : '0;
    end
  end

  a_one_handoff: assert property (@(posedge clk) disable iff (!rst_n)
    !(eq_start && cr_chk_start))
    else $error("eq_start and cr_chk_start in the same cycle");

endmodule

//--- design/cr_link_train.sv
// Clock recovery only; no rate or lane reduction, and no fallback from equalization
module cr_link_train (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic                                lpm_start_cr,
  input  logic                                driving_param_vld,
  input  logic                                config_param_vld,
  input  logic                                cr_done_vld,
  input  logic                                drive_setting_flag,
  input  logic                                err_cr_failed,
  input  logic                                cr_ctr_fire,
  input  logic                                ctrl_ack_flag,
  input  logic                                ctrl_native_failed,
  input  logic [cr_pkg::lvl_word_w-1:0]       vtg,
  input  logic [cr_pkg::lvl_word_w-1:0]       pre,
  input  logic [cr_pkg::bw_w-1:0]             link_bw_cr,
  input  logic [cr_pkg::lc_w-1:0]             link_lc_cr,
  input  logic [cr_pkg::max_lanes-1:0]        cr_done,
  input  logic [cr_pkg::lane_lvl_w-1:0]       max_vtg,
  input  logic [cr_pkg::lane_lvl_w-1:0]       max_pre,
  output logic                                fsm_cr_failed,
  output logic                                cr_completed,
  output logic                                cr_chk_start,
  output logic                                cr_ctr_start,
  output logic                                cr_transaction_vld,
  output logic                                eq_start,
  output logic                                cr_phy_instruct_vld,
  output logic [cr_pkg::lvl_word_w-1:0]       adj_vtg,
  output logic [cr_pkg::lvl_word_w-1:0]       adj_pre,
  output logic [cr_pkg::lvl_word_w-1:0]       new_vtg,
  output logic [cr_pkg::lvl_word_w-1:0]       new_pre,
  output logic [cr_pkg::bw_w-1:0]             new_bw,
  output logic [cr_pkg::bw_w-1:0]             cr_adj_bw,
  output logic [cr_pkg::lc_w-1:0]             new_lc,
  output logic [cr_pkg::lc_w-1:0]             cr_adj_lc,
  output logic [cr_pkg::aux_cmd_w-1:0]        cr_cmd,
  output logic [1:0]                          cr_phy_instruct,
  output logic [cr_pkg::aux_addr_w-1:0]       cr_address,
  output logic [cr_pkg::aux_len_w-1:0]        cr_len,
  output cr_pkg::aux_byte_u                   cr_data
);

  // Stored link setup shared by the request and handoff paths
  logic [cr_pkg::bw_w-1:0]       link_bw;
  logic [cr_pkg::lc_w-1:0]       link_lc;
  logic [cr_pkg::lvl_word_w-1:0] vtg_lvl;
  logic [cr_pkg::lvl_word_w-1:0] pre_lvl;
  logic [cr_pkg::lane_lvl_w-1:0] max_vtg_lvl;
  logic [cr_pkg::lane_lvl_w-1:0] max_pre_lvl;
  logic [cr_pkg::max_lanes-1:0]  cr_done_bits;
  logic                          drive_retry;
  cr_pkg::cr_state_t             state;

  cr_param_store cr_param_store_i (.*);

  cr_train_seq cr_train_seq_i (.*);

  cr_aux_request cr_aux_request_i (.*);

  cr_handoff_out cr_handoff_out_i (.*);

endmodule

//--- design/cr_param_store.sv
// Each group is held until its own strobe; retry flag clears only on the timer fire
module cr_param_store (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          config_param_vld,
  input  logic [cr_pkg::bw_w-1:0]       link_bw_cr,
  input  logic [cr_pkg::lc_w-1:0]       link_lc_cr,
  input  logic [cr_pkg::lane_lvl_w-1:0] max_vtg,
  input  logic [cr_pkg::lane_lvl_w-1:0] max_pre,
  input  logic                          driving_param_vld,
  input  logic [cr_pkg::lvl_word_w-1:0] vtg,
  input  logic [cr_pkg::lvl_word_w-1:0] pre,
  input  logic                          cr_done_vld,
  input  logic [cr_pkg::max_lanes-1:0]  cr_done,
  input  logic                          drive_setting_flag,
  input  logic                          cr_ctr_fire,
  output logic [cr_pkg::bw_w-1:0]       link_bw,
  output logic [cr_pkg::lc_w-1:0]       link_lc,
  output logic [cr_pkg::lane_lvl_w-1:0] max_vtg_lvl,
  output logic [cr_pkg::lane_lvl_w-1:0] max_pre_lvl,
  output logic [cr_pkg::lvl_word_w-1:0] vtg_lvl,
  output logic [cr_pkg::lvl_word_w-1:0] pre_lvl,
  output logic [cr_pkg::max_lanes-1:0]  cr_done_bits,
  output logic                          drive_retry
);

  // Link rate, lane count and level limits from the policy maker
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      link_bw     <= '0;
      link_lc     <= '0;
      max_vtg_lvl <= '0;
      max_pre_lvl <= '0;
    end
    else if (config_param_vld)
    begin
      link_bw     <= link_bw_cr;
      link_lc     <= link_lc_cr;
      max_vtg_lvl <= max_vtg;
      max_pre_lvl <= max_pre;
    end
  end

  // Current drive levels, two bits per lane
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      vtg_lvl <= '0;
      pre_lvl <= '0;
    end
    else if (driving_param_vld)
    begin
      vtg_lvl <= vtg;
      pre_lvl <= pre;
    end
  end

  // Status byte from the sink, and the retry marker
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      cr_done_bits <= '0;
      drive_retry  <= 1'b0;
    end
    else
    begin
      if (cr_done_vld)
        cr_done_bits <= cr_done;
      if (drive_setting_flag)
        drive_retry <= 1'b1;
      else if (cr_ctr_fire)
        drive_retry <= 1'b0;
    end
  end

  // Error checker and timer must not overlap, or the retry flag is lost
  a_retry_vs_fire: assert property (@(posedge clk) disable iff (!rst_n)
    !(drive_setting_flag && cr_ctr_fire))
    else $error("drive_setting_flag and cr_ctr_fire high together");

endmodule

//--- design/cr_pkg.sv
// Drive levels are 2 bits per lane for up to four lanes; lane count code 2 is invalid
package cr_pkg;

  //////////////////////////////////////////////////
  // Widths
  //////////////////////////////////////////////////
  localparam int lane_lvl_w = 2;
  localparam int max_lanes  = 4;
  localparam int lvl_word_w = lane_lvl_w * max_lanes;
  localparam int bw_w       = 8;
  localparam int lc_w       = 2;
  localparam int aux_addr_w = 20;
  localparam int aux_len_w  = 8;
  localparam int aux_cmd_w  = 2;

  // AUX native commands
  localparam logic [aux_cmd_w-1:0] aux_cmd_write = 2'd0;
  localparam logic [aux_cmd_w-1:0] aux_cmd_read  = 2'd1;

  // DPCD registers touched during clock recovery
  localparam logic [aux_addr_w-1:0] dpcd_link_bw_set          = 20'h00100;
  localparam logic [aux_addr_w-1:0] dpcd_training_pattern_set = 20'h00102;
  localparam logic [aux_addr_w-1:0] dpcd_training_lane0_set   = 20'h00103;
  localparam logic [aux_addr_w-1:0] dpcd_lane01_status        = 20'h00202;
  localparam logic [aux_addr_w-1:0] dpcd_adjust_request       = 20'h00206;

  // Pattern 1 with scrambling disabled
  localparam logic [7:0] tps1_no_scramble = 8'h21;
  localparam int         enh_frame_bit    = 7;
  localparam logic [1:0] phy_instr_cr     = 2'd0;

  //////////////////////////////////////////////////
  // Sequencer states, Gray coded
  //////////////////////////////////////////////////
  typedef enum logic [4:0] {
    st_idle             = 5'b00000,
    st_cfg_byte1        = 5'b00001,
    st_cfg_byte2        = 5'b00011,
    st_cfg_byte3        = 5'b00010,
    st_wait_ack_cfg     = 5'b00110,
    st_phy_cfg          = 5'b00111,
    st_lane0            = 5'b00100,
    st_lane1            = 5'b01100,
    st_lane2            = 5'b01101,
    st_lane3            = 5'b01111,
    st_wait_ack_drive   = 5'b01110,
    st_wait_ctr_fire    = 5'b01010,
    st_read_status      = 5'b01011,
    st_wait_ack_status  = 5'b01001,
    st_wait_data_status = 5'b01000,
    st_chk_status       = 5'b11000,
    st_read_adjust      = 5'b11001,
    st_wait_ack_adjust  = 5'b11011,
    st_wait_data_adjust = 5'b11010,
    st_eq_start         = 5'b11110,
    st_err_chk_start    = 5'b11111,
    st_cr_failed        = 5'b10111
  } cr_state_t;

  // TRAINING_LANEx_SET layout
  typedef struct packed {
    logic [1:0]            rsvd;
    logic                  max_pre_reached;
    logic [lane_lvl_w-1:0] pre_lvl;
    logic                  max_vtg_reached;
    logic [lane_lvl_w-1:0] vtg_lvl;
  } lane_drive_s;

  // One AUX data byte, raw or as a lane drive setting
  typedef union packed {
    logic [7:0]  raw;
    lane_drive_s drive;
  } aux_byte_u;

endpackage

//--- design/cr_train_seq.sv
// Waits indefinitely for ack, data and timer; a native failure drops back to idle
module cr_train_seq (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         lpm_start_cr,
  input  logic                         drive_setting_flag,
  input  logic                         err_cr_failed,
  input  logic                         ctrl_ack_flag,
  input  logic                         ctrl_native_failed,
  input  logic                         cr_ctr_fire,
  input  logic                         cr_done_vld,
  input  logic                         driving_param_vld,
  input  logic [cr_pkg::lc_w-1:0]      link_lc,
  input  logic [cr_pkg::max_lanes-1:0] cr_done_bits,
  output cr_pkg::cr_state_t            state
);

  cr_pkg::cr_state_t next_state;
  logic              lanes_done;

  // Ack wait step shared by every reply wait
  function automatic cr_pkg::cr_state_t ack_step(input logic ack,
                                                 input logic failed,
                                                 input cr_pkg::cr_state_t go,
                                                 input cr_pkg::cr_state_t stay);
    if (ack)
      return go;
    else if (failed)
      return cr_pkg::st_idle;
    else
      return stay;
  endfunction

  // Done bits of the active lanes only
  always_comb
  begin
    case (link_lc)
      2'd0:    lanes_done = cr_done_bits[0];
      2'd1:    lanes_done = &cr_done_bits[1:0];
      default: lanes_done = &cr_done_bits;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      state <= cr_pkg::st_idle;
    else
      state <= next_state;
  end

  //////////////////////////////////////////////////
  // Next state
  //////////////////////////////////////////////////
  always_comb
  begin
    next_state = state;
    case (state)
      cr_pkg::st_idle:
      begin
        if (lpm_start_cr)
          next_state = cr_pkg::st_cfg_byte1;
        else if (drive_setting_flag)
          next_state = cr_pkg::st_lane0;
        else if (err_cr_failed)
          next_state = cr_pkg::st_cr_failed;
      end
      cr_pkg::st_cfg_byte1: next_state = cr_pkg::st_cfg_byte2;
      cr_pkg::st_cfg_byte2: next_state = cr_pkg::st_cfg_byte3;
      cr_pkg::st_cfg_byte3: next_state = cr_pkg::st_wait_ack_cfg;
      cr_pkg::st_wait_ack_cfg:
        next_state = ack_step(ctrl_ack_flag, ctrl_native_failed,
                              cr_pkg::st_phy_cfg, state);
      cr_pkg::st_phy_cfg:   next_state = cr_pkg::st_lane0;
      // Lane count picks how many lane bytes follow
      cr_pkg::st_lane0:
        next_state = (link_lc == 2'd0) ? cr_pkg::st_wait_ack_drive : cr_pkg::st_lane1;
      cr_pkg::st_lane1:
        next_state = (link_lc == 2'd1) ? cr_pkg::st_wait_ack_drive : cr_pkg::st_lane2;
      cr_pkg::st_lane2:     next_state = cr_pkg::st_lane3;
      cr_pkg::st_lane3:     next_state = cr_pkg::st_wait_ack_drive;
      cr_pkg::st_wait_ack_drive:
        next_state = ack_step(ctrl_ack_flag, ctrl_native_failed,
                              cr_pkg::st_wait_ctr_fire, state);
      cr_pkg::st_wait_ctr_fire:
      begin
        if (cr_ctr_fire)
          next_state = cr_pkg::st_read_status;
      end
      cr_pkg::st_read_status: next_state = cr_pkg::st_wait_ack_status;
      cr_pkg::st_wait_ack_status:
        next_state = ack_step(ctrl_ack_flag, ctrl_native_failed,
                              cr_pkg::st_wait_data_status, state);
      cr_pkg::st_wait_data_status:
      begin
        if (cr_done_vld)
          next_state = cr_pkg::st_chk_status;
      end
      cr_pkg::st_chk_status:
      begin
        if (link_lc == 2'd2)
          next_state = cr_pkg::st_idle;
        else if (lanes_done)
          next_state = cr_pkg::st_eq_start;
        else
          next_state = cr_pkg::st_read_adjust;
      end
      cr_pkg::st_read_adjust: next_state = cr_pkg::st_wait_ack_adjust;
      cr_pkg::st_wait_ack_adjust:
        next_state = ack_step(ctrl_ack_flag, ctrl_native_failed,
                              cr_pkg::st_wait_data_adjust, state);
      cr_pkg::st_wait_data_adjust:
      begin
        if (driving_param_vld)
          next_state = cr_pkg::st_err_chk_start;
      end
      default: next_state = cr_pkg::st_idle;
    endcase
  end

  a_state_legal: assert property (@(posedge clk) disable iff (!rst_n)
    state inside {cr_pkg::st_idle, cr_pkg::st_cfg_byte1, cr_pkg::st_cfg_byte2,
                  cr_pkg::st_cfg_byte3, cr_pkg::st_wait_ack_cfg, cr_pkg::st_phy_cfg,
                  cr_pkg::st_lane0, cr_pkg::st_lane1, cr_pkg::st_lane2, cr_pkg::st_lane3,
                  cr_pkg::st_wait_ack_drive, cr_pkg::st_wait_ctr_fire,
                  cr_pkg::st_read_status, cr_pkg::st_wait_ack_status,
                  cr_pkg::st_wait_data_status, cr_pkg::st_chk_status,
                  cr_pkg::st_read_adjust, cr_pkg::st_wait_ack_adjust,
                  cr_pkg::st_wait_data_adjust, cr_pkg::st_eq_start,
                  cr_pkg::st_err_chk_start, cr_pkg::st_cr_failed})
    else $error("sequencer state outside the encoding");

endmodule

//--- run_sim.sh
#!/bin/sh
# Compile with Verilator, run, and decide by the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/100ps \
  --top-module tb_cr_link_train -f cr_link_train.f \
  && ./obj_dir/Vtb_cr_link_train > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "Build or simulation run failed"; exit 1; }
cat sim.log
grep -q "FAIL: see errors above" sim.log && { echo "Simulation failed"; exit 1; }
echo "Simulation passed"

//--- test/tb_clk_gen.sv
// Free-running clock that starts low; the period must be an even number of ns
module tb_clk_gen #(
  parameter int period_ns = 20
) (
  output logic clk
);

  timeunit 1ns;
  timeprecision 100ps;

  initial
  begin
    clk = 1'b0;
    forever
      #(period_ns / 2) clk = ~clk;
  end

endmodule

//--- test/tb_cr_link_train.sv
// Sink and timer replies come from the row runner; lane count code 2 expects no handoff
module tb_cr_link_train;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int n_rows      = 7;
  localparam int row_limit   = 250;
  localparam int ack_dly     = 2;
  localparam int watchdog_ns = n_rows * 300 * 20 + 16 * 20;

  // Row events and expected handoff kinds
  localparam logic [1:0] ev_start  = 2'd0;
  localparam logic [1:0] ev_retry  = 2'd1;
  localparam logic [1:0] ev_err    = 2'd2;
  localparam logic [1:0] ev_native = 2'd3;
  localparam logic [1:0] hd_none   = 2'd0;
  localparam logic [1:0] hd_eq     = 2'd1;
  localparam logic [1:0] hd_chk    = 2'd2;
  localparam logic [1:0] hd_fail   = 2'd3;

  typedef struct packed {
    logic [1:0] lc;
    logic [7:0] bw;
    logic [7:0] vtg;
    logic [7:0] pre;
    logic [1:0] mvtg;
    logic [1:0] mpre;
    logic [3:0] done;
    logic [7:0] avtg;
    logic [7:0] apre;
    logic [1:0] ev;
    logic [1:0] hand;
  } row_t;

  logic clk, rst_n;
  logic lpm_start_cr, driving_param_vld, config_param_vld, cr_done_vld;
  logic drive_setting_flag, err_cr_failed, cr_ctr_fire, ctrl_ack_flag, ctrl_native_failed;
  logic [7:0] vtg, pre, link_bw_cr;
  logic [1:0] link_lc_cr, max_vtg, max_pre;
  logic [3:0] cr_done;
  logic fsm_cr_failed, cr_completed, cr_chk_start, cr_ctr_start;
  logic cr_transaction_vld, eq_start, cr_phy_instruct_vld;
  logic [7:0] adj_vtg, adj_pre, new_vtg, new_pre, new_bw, cr_adj_bw, cr_len;
  logic [1:0] new_lc, cr_adj_lc, cr_cmd, cr_phy_instruct;
  logic [19:0] cr_address;
  cr_pkg::aux_byte_u cr_data;

  row_t        rows [n_rows];
  logic [37:0] exp_q [$];
  logic [37:0] got_q [$];
  int          err_cnt = 0;
  int          chk_cnt = 0;
  integer      seed = 33;
  int          r;

  tb_clk_gen clk_gen_i (.clk(clk));

  cr_link_train cr_link_train_i (.*);

  task automatic tick();
    @(posedge clk);
    #2;
  endtask

  task automatic check(input logic ok, input string msg);
    chk_cnt++;
    assert (ok)
    else
    begin
      err_cnt++;
      $display("FAIL %0d ns: %s", $time, msg);
    end
  endtask

  function automatic logic outputs_idle();
    return {fsm_cr_failed, cr_completed, cr_chk_start, cr_ctr_start, cr_transaction_vld,
            eq_start, cr_phy_instruct_vld, adj_vtg, adj_pre, new_vtg, new_pre, new_bw,
            cr_adj_bw, new_lc, cr_adj_lc, cr_cmd, cr_phy_instruct, cr_address, cr_len,
            cr_data} == '0;
  endfunction

  // Lane byte: zeros, max pre flag, pre level, max swing flag, swing level
  function automatic logic [7:0] drive_byte(input row_t t, input int lane);
    logic [1:0] v;
    logic [1:0] p;
    v = t.vtg[lane*2 +: 2];
    p = t.pre[lane*2 +: 2];
    return {2'b00, p == t.mpre, p, v == t.mvtg, v};
  endfunction

  //////////////////////////////////////////////////
  // Expected AUX requests as {cmd, address, len, data}
  //////////////////////////////////////////////////
  task automatic build_expected(input row_t t);
    int         n;
    int         i;
    logic [7:0] phy_len;
    exp_q.delete();
    n = (t.lc == 2'd0) ? 1 : (t.lc == 2'd1) ? 2 : 4;
    // Invalid code counts as one lane in the pattern length
    phy_len = (t.lc == 2'd3) ? 8'd4 : (t.lc == 2'd1) ? 8'd2 : 8'd1;
    if (t.ev == ev_err)
      return;
    if (t.ev != ev_retry)
    begin
      exp_q.push_back({cr_pkg::aux_cmd_write, cr_pkg::dpcd_link_bw_set, 8'd2, t.bw});
      exp_q.push_back({2'd0, 20'd0, 8'd0, 8'h80 | (8'(t.lc) + 8'd1)});
      exp_q.push_back(38'd0);
    end
    if (t.ev == ev_native)
      return;
    if (t.ev != ev_retry)
      exp_q.push_back({cr_pkg::aux_cmd_write, cr_pkg::dpcd_training_pattern_set, phy_len, 8'h21});
    for (i = 0; i < n; i++)
    begin
      if (i == 0 && t.ev == ev_retry)
        exp_q.push_back({cr_pkg::aux_cmd_write, cr_pkg::dpcd_training_lane0_set, 8'(n - 1),
                         drive_byte(t, i)});
      else
        exp_q.push_back({2'd0, 20'd0, 8'd0, drive_byte(t, i)});
    end
    exp_q.push_back({cr_pkg::aux_cmd_read, cr_pkg::dpcd_lane01_status, 8'd1, 8'd0});
    if (t.hand == hd_chk)
      exp_q.push_back({cr_pkg::aux_cmd_read, cr_pkg::dpcd_adjust_request, 8'd1, 8'd0});
  endtask

  //////////////////////////////////////////////////
  // One table row with the sink and timer model
  //////////////////////////////////////////////////
  task automatic run_row(input int idx);
    row_t        t;
    int          cyc, ack_cnt, fire_cnt, quiet, i, first_cyc, phy_cnt;
    logic        in_burst, armed, fired, reply_due, native_used;
    logic [1:0]  seen;
    logic [19:0] read_addr;
    t = rows[idx];
    build_expected(t);
    got_q.delete();
    cyc = 0;
    ack_cnt = -1;
    fire_cnt = 0;
    quiet = 0;
    first_cyc = -1;
    phy_cnt = 0;
    {in_burst, armed, fired, reply_due, native_used} = '0;
    seen = hd_none;
    read_addr = '0;
    // Link setup and starting levels
    tick();
    config_param_vld = 1'b1;
    driving_param_vld = 1'b1;
    {link_bw_cr, link_lc_cr, max_vtg, max_pre} = {t.bw, t.lc, t.mvtg, t.mpre};
    {vtg, pre, cr_done} = {t.vtg, t.pre, t.done};
    tick();
    config_param_vld = 1'b0;
    driving_param_vld = 1'b0;
    lpm_start_cr = (t.ev == ev_start || t.ev == ev_native);
    drive_setting_flag = (t.ev == ev_retry);
    err_cr_failed = (t.ev == ev_err);
    while (seen == hd_none && quiet != 1 && cyc < row_limit)
    begin
      tick();
      cyc++;
      {lpm_start_cr, drive_setting_flag, err_cr_failed, ctrl_ack_flag} = '0;
      {ctrl_native_failed, cr_ctr_fire, cr_done_vld, driving_param_vld} = '0;
      if (cr_transaction_vld)
      begin
        if (got_q.size() == 0)
          first_cyc = cyc;
        got_q.push_back({cr_cmd, cr_address, cr_len, cr_data.raw});
        if (cr_cmd == cr_pkg::aux_cmd_read)
          read_addr = cr_address;
        in_burst = 1'b1;
      end
      else if (in_burst)
      begin
        in_burst = 1'b0;
        ack_cnt = ack_dly;
      end
      // Read data follows the acknowledge by one cycle
      if (reply_due)
      begin
        if (read_addr == cr_pkg::dpcd_lane01_status)
        begin
          cr_done_vld = 1'b1;
          cr_done = t.done;
          if (t.hand == hd_none)
            quiet = 6;
        end
        else
        begin
          driving_param_vld = 1'b1;
          vtg = t.avtg;
          pre = t.apre;
        end
        reply_due = 1'b0;
        read_addr = '0;
      end
      if (ack_cnt > 0)
        ack_cnt--;
      else if (ack_cnt == 0)
      begin
        if (t.ev == ev_native && !native_used)
        begin
          ctrl_native_failed = 1'b1;
          native_used = 1'b1;
          quiet = 6;
        end
        else
        begin
          ctrl_ack_flag = 1'b1;
          reply_due = (read_addr != '0);
        end
        ack_cnt = -1;
      end
      if (cr_ctr_start && !armed)
      begin
        armed = 1'b1;
        fire_cnt = $unsigned($random(seed)) % 6 + 1;
      end
      if (armed && !fired)
      begin
        check(cr_ctr_start, "cr_ctr_start dropped before the timer fired");
        if (fire_cnt == 0)
        begin
          cr_ctr_fire = 1'b1;
          fired = 1'b1;
        end
        else
          fire_cnt--;
      end
      if (cr_phy_instruct_vld)
      begin
        phy_cnt++;
        check(cr_transaction_vld && cr_address == cr_pkg::dpcd_training_pattern_set &&
              cr_adj_lc == t.lc && cr_adj_bw == t.bw && cr_phy_instruct == 2'd0,
              $sformatf("row %0d PHY step lc %0d bw %h", idx, cr_adj_lc, cr_adj_bw));
      end
      if (eq_start)
      begin
        seen = hd_eq;
        check(cr_completed && new_vtg == t.vtg && new_pre == t.pre && new_bw == t.bw &&
              new_lc == t.lc, $sformatf("row %0d eq handoff vtg %h pre %h bw %h lc %0d",
              idx, new_vtg, new_pre, new_bw, new_lc));
      end
      else if (cr_chk_start)
      begin
        seen = hd_chk;
        check(adj_vtg == t.avtg && adj_pre == t.apre,
              $sformatf("row %0d adjust handoff vtg %h pre %h", idx, adj_vtg, adj_pre));
      end
      else if (fsm_cr_failed)
        seen = hd_fail;
      if (quiet > 1)
        quiet--;
    end
    assert (cyc < row_limit)
    else
    begin
      err_cnt++;
      $display("Row %0d never reached its end within %0d cycles", idx, row_limit);
    end
    check(seen == t.hand, $sformatf("row %0d handoff %0d, expected %0d", idx, seen, t.hand));
    check(got_q.size() == exp_q.size(), $sformatf("row %0d saw %0d requests, expected %0d",
          idx, got_q.size(), exp_q.size()));
    for (i = 0; i < got_q.size() && i < exp_q.size(); i++)
      check(got_q[i] == exp_q[i], $sformatf("row %0d request %0d is %h, expected %h",
            idx, i, got_q[i], exp_q[i]));
    check(phy_cnt == ((t.ev == ev_start) ? 1 : 0),
          $sformatf("row %0d PHY step seen %0d times", idx, phy_cnt));
    // First byte two edges after the event is driven
    if (t.ev != ev_err)
      check(first_cyc == 2, $sformatf("row %0d first request at cycle %0d, expected 2",
            idx, first_cyc));
    // Pulses last one cycle, so the outputs are back to zero on the next edge
    tick();
    check(outputs_idle(), $sformatf("row %0d outputs not idle after the row", idx));
  endtask

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////
  initial
  begin
    rst_n = 1'b0;
    {lpm_start_cr, driving_param_vld, config_param_vld, cr_done_vld} = '0;
    {drive_setting_flag, err_cr_failed, cr_ctr_fire, ctrl_ack_flag, ctrl_native_failed} = '0;
    {vtg, pre, link_bw_cr, link_lc_cr, cr_done, max_vtg, max_pre} = '0;
    // lc, bw, vtg, pre, max vtg, max pre, done, adjusted vtg, adjusted pre, event, handoff
    rows[0] = {2'd3, 8'h0a, 8'he4, 8'h1b, 2'd2, 2'd3, 4'hf, 8'h00, 8'h00, ev_start, hd_eq};
    rows[1] = {2'd1, 8'h14, 8'h05, 8'h00, 2'd3, 2'd3, 4'h1, 8'h0a, 8'h05, ev_start, hd_chk};
    rows[2] = {2'd1, 8'h14, 8'h0a, 8'h05, 2'd2, 2'd1, 4'h3, 8'h00, 8'h00, ev_retry, hd_eq};
    rows[3] = {2'd0, 8'h06, 8'h00, 8'h00, 2'd3, 2'd3, 4'h0, 8'h00, 8'h00, ev_err, hd_fail};
    rows[4] = {2'd0, 8'h06, 8'h01, 8'h00, 2'd3, 2'd3, 4'h1, 8'h00, 8'h00, ev_native, hd_none};
    rows[5] = {2'd0, 8'h06, 8'h03, 8'h02, 2'd3, 2'd3, 4'h1, 8'h00, 8'h00, ev_start, hd_eq};
    rows[6] = {2'd2, 8'h0a, 8'h1b, 8'he4, 2'd1, 2'd2, 4'hf, 8'h00, 8'h00, ev_start, hd_none};
    repeat (16) @(posedge clk);
    #2;
    check(outputs_idle(), "outputs active during reset");
    rst_n = 1'b1;
    repeat (4)
    begin
      tick();
      check(outputs_idle(), "outputs active after reset");
    end
    for (r = 0; r < n_rows; r++)
      run_row(r);
    $display("Checks: %0d, errors: %0d", chk_cnt, err_cnt);
    if (err_cnt == 0)
      $display("PASS: all tests");
    else
      $display("FAIL: see errors above");
    $finish;
  end

  // Watchdog sized from the row count
  initial
  begin
    #(watchdog_ns);
    $display("Watchdog expired at %0d ns, the run did not complete", $time);
    $display("FAIL: see errors above");
    $finish;
  end

endmodule
